//--- Bender.yml
package:
  name: rv32_exu

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - exu_pkg.sv
      - exu_issue_reg.sv
      - exu_alu_branch.sv
      - exu_commit.sv
      - exu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clkgen.sv
      - tb_exu.sv

//--- exu_alu_branch.sv
// purely combinational; result is zero for ops with no register write, unknown ops step pc+4
`timescale 1ns/1ps
`include "exu_settings.svh"

module exu_alu_branch (
  input  logic [`EXU_XLEN-1:0] held_pc,
  input  logic [`EXU_XLEN-1:0] held_rs1,
  input  logic [`EXU_XLEN-1:0] held_rs2,
  input  logic [`EXU_XLEN-1:0] held_imm,
  input  exu_pkg::exu_op_e     held_op,
  input  logic [`EXU_XLEN-1:0] held_mtvec,
  input  logic [`EXU_XLEN-1:0] held_mepc,
  output logic [`EXU_XLEN-1:0] alu_result,
  output logic [`EXU_XLEN-1:0] next_pc
);

  import exu_pkg::*;

  logic                    use_imm;
  logic [`EXU_XLEN-1:0]    opb;
  logic [`EXU_SHAMT_W-1:0] shamt;
  logic [`EXU_XLEN-1:0]    pc_plus4;
  logic [`EXU_XLEN-1:0]    pc_target;
  logic [`EXU_XLEN-1:0]    jalr_sum;
  logic                    eq;
  logic                    lt_s;
  logic                    lt_u;
  logic                    taken;

  // immediate forms take imm as the second operand
  always_comb begin
    case (held_op)
      op_addi, op_xori, op_andi, op_ori, op_slti,
      op_slli, op_srli, op_srai: use_imm = 1'b1;
      default:                   use_imm = 1'b0;
    endcase
  end

  assign opb       = use_imm ? held_imm : held_rs2;
  assign shamt     = opb[`EXU_SHAMT_W-1:0];
  assign pc_plus4  = held_pc + `EXU_XLEN'(`EXU_INSN_BYTES);
  assign pc_target = held_pc + held_imm;
  assign jalr_sum  = held_rs1 + held_imm;

  // shared compares, branches always see rs2 here
  assign eq   = (held_rs1 == opb);
  assign lt_s = ($signed(held_rs1) < $signed(opb));
  assign lt_u = (held_rs1 < opb);

  always_comb begin
    case (held_op)
      op_addi, op_add: alu_result = held_rs1 + opb;
      op_sub:          alu_result = held_rs1 - held_rs2;
      op_xori, op_xor: alu_result = held_rs1 ^ opb;
      op_andi, op_and: alu_result = held_rs1 & opb;
      op_ori, op_or:   alu_result = held_rs1 | opb;
      op_sll, op_slli: alu_result = held_rs1 << shamt;
      op_srl, op_srli: alu_result = held_rs1 >> shamt;
      op_sra, op_srai: alu_result = $signed(held_rs1) >>> shamt;
      op_slt, op_slti: alu_result = {{(`EXU_XLEN-1){1'b0}}, lt_s};
      op_sltu:         alu_result = {{(`EXU_XLEN-1){1'b0}}, lt_u};
      op_seqz:         alu_result = {{(`EXU_XLEN-1){1'b0}}, (held_rs1 == '0)};
      op_snez:         alu_result = {{(`EXU_XLEN-1){1'b0}}, (held_rs2 != '0)}; // tests rs2
      op_zextb:        alu_result = {{(`EXU_XLEN-8){1'b0}}, held_rs1[7:0]};
      op_lui:          alu_result = held_imm;
      op_auipc:        alu_result = pc_target;
      op_jal, op_jalr: alu_result = pc_plus4; // link address
      default:         alu_result = '0;
    endcase
  end

  always_comb begin
    case (held_op)
      op_beq:  taken = eq;
      op_bne:  taken = ~eq;
      op_blt:  taken = lt_s;
      op_bge:  taken = ~lt_s;
      op_bltu: taken = lt_u;
      op_bgeu: taken = ~lt_u;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    case (held_op)
      op_jal:   next_pc = pc_target;
      op_jalr:  next_pc = {jalr_sum[`EXU_XLEN-1:1], 1'b0};
      op_ecall: next_pc = held_mtvec;
      op_mret:  next_pc = held_mepc;
      op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: begin
        next_pc = taken ? pc_target : pc_plus4;
      end
      default:  next_pc = pc_plus4;
    endcase
  end

endmodule

//--- exu_commit.sv
// output side of the stage; flags read low whenever no instruction is held
`timescale 1ns/1ps
`include "exu_settings.svh"

module exu_commit (
  input  logic                   held_valid,
  input  exu_pkg::exu_op_e       held_op,
  input  logic [`EXU_XLEN-1:0]   held_rs1,
  input  logic [`EXU_XLEN-1:0]   held_rs2,
  input  logic [`EXU_XLEN-1:0]   held_imm,
  input  logic [`EXU_REG_AW-1:0] held_rd_addr,
  input  logic                   held_rd_wen,
  input  logic [`EXU_XLEN-1:0]   alu_result,
  input  logic [`EXU_XLEN-1:0]   next_pc,
  input  logic                   commit_ready,
  output logic                   commit_valid,
  output logic                   commit_fire,
  output logic [`EXU_XLEN-1:0]   rd_data,
  output logic [`EXU_REG_AW-1:0] rd_addr,
  output logic                   rd_wen,
  output logic [`EXU_XLEN-1:0]   next_pc_out,
  output logic                   is_ecall,
  output logic                   is_mret,
  output logic                   is_mem,
  output logic [`EXU_XLEN-1:0]   mem_addr,
  output logic [`EXU_XLEN-1:0]   mem_wdata,
  output logic [`EXU_MASK_W-1:0] mem_wmask,
  output logic                   mem_wen,
  output logic [`EXU_SIZE_W-1:0] mem_size,
  output logic                   mem_unsigned
);

  import exu_pkg::*;

  localparam logic [`EXU_SIZE_W-1:0] size_byte = `EXU_SIZE_W'(0);
  localparam logic [`EXU_SIZE_W-1:0] size_half = `EXU_SIZE_W'(1);
  localparam logic [`EXU_SIZE_W-1:0] size_word = `EXU_SIZE_W'(2);

  logic                   is_load;
  logic                   is_store;
  logic                   uns;
  logic [`EXU_SIZE_W-1:0] size_code;
  logic [`EXU_MASK_W-1:0] byte_mask;

  // mask stays in the low lanes for the lsu to shift by address
  always_comb begin
    is_load   = 1'b0;
    is_store  = 1'b0;
    size_code = size_byte;
    byte_mask = '0;
    case (held_op)
      op_lw, op_lh, op_lhu, op_lb, op_lbu: is_load  = 1'b1;
      op_sw, op_sh, op_sb:                 is_store = 1'b1;
      default: ;
    endcase
    case (held_op)
      op_lw, op_sw:         size_code = size_word;
      op_lh, op_lhu, op_sh: size_code = size_half;
      default: ;
    endcase
    case (held_op)
      op_sw:   byte_mask = 4'b1111;
      op_sh:   byte_mask = 4'b0011;
      op_sb:   byte_mask = 4'b0001;
      default: ;
    endcase
  end

  assign uns = (held_op == op_lbu) | (held_op == op_lhu); // zero extended loads

  assign commit_valid = held_valid;
  assign commit_fire  = held_valid & commit_ready; // frees the issue slot

  assign rd_data     = alu_result;
  assign rd_addr     = held_rd_addr;
  assign rd_wen      = held_valid & held_rd_wen;
  assign next_pc_out = next_pc;

  assign is_ecall = held_valid & (held_op == op_ecall);
  assign is_mret  = held_valid & (held_op == op_mret);

  assign is_mem       = held_valid & (is_load | is_store);
  assign mem_wen      = held_valid & is_store;
  assign mem_unsigned = held_valid & uns;
  assign mem_addr     = (is_load | is_store) ? held_rs1 + held_imm : '0;
  assign mem_wdata    = is_store ? held_rs2 : '0;
  assign mem_wmask    = byte_mask;
  assign mem_size     = size_code;

endmodule

//--- exu_golden.txt
# op pc rs1 rs2 imm mtvec mepc rd_addr rd_wen | rd_data next_pc is_mem mem_addr mem_wdata
# mem_wmask mem_wen mem_size mem_unsigned is_ecall is_mret, every field in hex
0 100 5 0 7 800 300 1 1 c 104 0 0 0 0 0 0 0 0 0
5 104 7fffffff 1 0 800 300 3 1 80000000 108 0 0 0 0 0 0 0 0 0
c 108 5 7 0 800 300 4 1 fffffffe 10c 0 0 0 0 0 0 0 0 0
10 10c ff00ff00 ff00ff0 0 800 300 5 1 f000f00 110 0 0 0 0 0 0 0 0 0
14 110 f0 f 0 800 300 6 1 ff 114 0 0 0 0 0 0 0 0 0
17 114 aaaa5555 ffff0000 0 800 300 7 1 55555555 118 0 0 0 0 0 0 0 0 0
13 118 1234 0 ff 800 300 8 1 34 11c 0 0 0 0 0 0 0 0 0
25 11c 1200 0 34 800 300 9 1 1234 120 0 0 0 0 0 0 0 0 0
d 120 1 24 0 800 300 a 1 10 124 0 0 0 0 0 0 0 0 0
19 124 3 0 1f 800 300 b 1 80000000 128 0 0 0 0 0 0 0 0 0
22 128 80000000 4 0 800 300 c 1 8000000 12c 0 0 0 0 0 0 0 0 0
21 12c 80000000 4 0 800 300 d 1 f8000000 130 0 0 0 0 0 0 0 0 0
11 130 7ffffff0 0 4 800 300 e 1 7ffffff 134 0 0 0 0 0 0 0 0 0
1d 134 ffffffff 1 0 800 300 f 1 1 138 0 0 0 0 0 0 0 0 0
1c 138 ffffffff 1 0 800 300 10 1 0 13c 0 0 0 0 0 0 0 0 0
26 13c fffffffa 0 fffffffb 800 300 11 1 1 140 0 0 0 0 0 0 0 0 0
a 140 0 9 0 800 300 12 1 1 144 0 0 0 0 0 0 0 0 0
12 144 0 9 0 800 300 13 1 1 148 0 0 0 0 0 0 0 0 0
f 148 12345687 0 0 800 300 14 1 87 14c 0 0 0 0 0 0 0 0 0
1 14c 0 0 12345000 800 300 15 1 12345000 150 0 0 0 0 0 0 0 0 0
2 150 0 0 1000 800 300 16 1 1150 154 0 0 0 0 0 0 0 0 0
3 154 0 0 40 800 300 1 1 158 194 0 0 0 0 0 0 0 0 0
4 194 2001 0 4 800 300 1 1 198 2004 0 0 0 0 0 0 0 0 0
6 200 7 7 10 800 300 0 0 0 210 0 0 0 0 0 0 0 0 0
7 210 7 7 20 800 300 0 0 0 214 0 0 0 0 0 0 0 0 0
1e 214 fffffffe 1 fffffff0 800 300 0 0 0 204 0 0 0 0 0 0 0 0 0
15 204 fffffffe 1 8 800 300 0 0 0 208 0 0 0 0 0 0 0 0 0
1b 208 fffffffe 1 8 800 300 0 0 0 20c 0 0 0 0 0 0 0 0 0
1a 20c fffffffe 1 100 800 300 0 0 0 30c 0 0 0 0 0 0 0 0 0
8 300 1000 0 8 800 300 6 1 0 304 1 1008 0 0 0 2 0 0 0
1f 304 1000 0 fffffffe 800 300 7 1 0 308 1 ffe 0 0 0 1 0 0 0
20 308 1000 0 2 800 300 8 1 0 30c 1 1002 0 0 0 1 1 0 0
24 30c 2000 0 3 800 300 9 1 0 310 1 2003 0 0 0 0 0 0 0
18 310 2000 0 1 800 300 a 1 0 314 1 2001 0 0 0 0 1 0 0
9 314 3000 deadbeef 4 800 300 0 0 0 318 1 3004 deadbeef f 1 2 0 0 0
34 318 3000 cafe 6 800 300 0 0 0 31c 1 3006 cafe 3 1 1 0 0 0
23 31c 3000 a5 7 800 300 0 0 0 320 1 3007 a5 1 1 0 0 0 0
32 320 0 0 0 800 300 0 0 0 800 0 0 0 0 0 0 0 1 0
33 800 0 0 0 800 324 0 0 0 324 0 0 0 0 0 0 0 0 1
28 324 5 6 0 800 300 1 1 0 328 0 0 0 0 0 0 0 0 0

//--- exu_issue_reg.sv
// one-entry issue buffer; a new instruction is taken only after the held one commits
`timescale 1ns/1ps
`include "exu_settings.svh"

module exu_issue_reg (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   issue_valid,
  output logic                   issue_ready,
  input  logic [`EXU_XLEN-1:0]   pc,
  input  logic [`EXU_XLEN-1:0]   rs1_data,
  input  logic [`EXU_XLEN-1:0]   rs2_data,
  input  logic [`EXU_XLEN-1:0]   imm,
  input  exu_pkg::exu_op_e       op,
  input  logic [`EXU_REG_AW-1:0] rd_addr,
  input  logic                   rd_wen,
  input  logic [`EXU_XLEN-1:0]   mtvec,
  input  logic [`EXU_XLEN-1:0]   mepc,
  input  logic                   commit_fire,
  output logic                   held_valid,
  output logic [`EXU_XLEN-1:0]   held_pc,
  output logic [`EXU_XLEN-1:0]   held_rs1,
  output logic [`EXU_XLEN-1:0]   held_rs2,
  output logic [`EXU_XLEN-1:0]   held_imm,
  output exu_pkg::exu_op_e       held_op,
  output logic [`EXU_REG_AW-1:0] held_rd_addr,
  output logic                   held_rd_wen,
  output logic [`EXU_XLEN-1:0]   held_mtvec,
  output logic [`EXU_XLEN-1:0]   held_mepc
);

  import exu_pkg::*;

  logic accept;

  // no bypass, ready only when the slot is empty
  assign issue_ready = ~held_valid;
  assign accept      = issue_valid & issue_ready;

  // idle/exec state collapsed into a single valid bit
  always_ff @(posedge clk) begin
    if (rst) begin
      held_valid <= 1'b0;
    end else if (accept) begin
      held_valid <= 1'b1;
    end else if (commit_fire) begin
      held_valid <= 1'b0; // slot frees on the output transfer
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      held_pc      <= '0;
      held_rs1     <= '0;
      held_rs2     <= '0;
      held_imm     <= '0;
      held_op      <= op_addi;
      held_rd_addr <= '0;
      held_rd_wen  <= 1'b0;
      held_mtvec   <= '0;
      held_mepc    <= '0;
    end else if (accept) begin
      held_pc      <= pc;
      held_rs1     <= rs1_data;
      held_rs2     <= rs2_data;
      held_imm     <= imm;
      held_op      <= op;
      held_rd_addr <= rd_addr;
      held_rd_wen  <= rd_wen;
      held_mtvec   <= mtvec;
      held_mepc    <= mepc;
    end
  end

endmodule

//--- exu_pkg.sv
// op-code values follow the decode stage encoding; csr ops and ebreak are not listed
`include "exu_settings.svh"

package exu_pkg;

  // every op the execute stage handles, anything else completes as a nop
  typedef enum logic [`EXU_OP_W-1:0] {
    op_addi  = 0,
    op_lui   = 1,
    op_auipc = 2,
    op_jal   = 3,
    op_jalr  = 4,
    op_add   = 5,
    op_beq   = 6,
    op_bne   = 7,
    op_lw    = 8,
    op_sw    = 9,
    op_seqz  = 10,
    op_sub   = 12,
    op_sll   = 13,
    op_xori  = 14,
    op_zextb = 15,
    op_and   = 16,
    op_srai  = 17,
    op_snez  = 18,
    op_andi  = 19,
    op_or    = 20,
    op_bge   = 21,
    op_srli  = 22,
    op_xor   = 23,
    op_lbu   = 24,
    op_slli  = 25,
    op_bgeu  = 26,
    op_bltu  = 27,
    op_sltu  = 28,
    op_slt   = 29,
    op_blt   = 30,
    op_lh    = 31,
    op_lhu   = 32,
    op_sra   = 33,
    op_srl   = 34,
    op_sb    = 35,
    op_lb    = 36,
    op_ori   = 37,
    op_slti  = 38,
    op_ecall = 50, // trap entry
    op_mret  = 51, // trap return
    op_sh    = 52
  } exu_op_e;

endpackage

//--- exu_settings.svh
// project widths, fixed for RV32; op codes wider than EXU_OP_W are not decoded
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// data path and address width
`define EXU_XLEN 32

// op-code width from the decode stage
`define EXU_OP_W 6

// register file address width
`define EXU_REG_AW 5

// pc step for a sequential instruction, no compressed support
`define EXU_INSN_BYTES 4

// shift amount bits taken from rs2 or imm
`define EXU_SHAMT_W 5

// one bit per byte lane of a word store
`define EXU_MASK_W 4

// access size code, 0 byte / 1 half / 2 word
`define EXU_SIZE_W 3

`endif

//--- exu_top.sv
// single instruction in flight, at most one instruction every two cycles
`timescale 1ns/1ps
`include "exu_settings.svh"

module exu_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   issue_valid,
  output logic                   issue_ready,
  input  logic [`EXU_XLEN-1:0]   pc,
  input  logic [`EXU_XLEN-1:0]   rs1_data,
  input  logic [`EXU_XLEN-1:0]   rs2_data,
  input  logic [`EXU_XLEN-1:0]   imm,
  input  exu_pkg::exu_op_e       op,
  input  logic [`EXU_REG_AW-1:0] rd_addr,
  input  logic                   rd_wen,
  input  logic [`EXU_XLEN-1:0]   mtvec,
  input  logic [`EXU_XLEN-1:0]   mepc,
  input  logic                   commit_ready,
  output logic                   commit_valid,
  output logic [`EXU_XLEN-1:0]   rd_data,
  output logic [`EXU_REG_AW-1:0] rd_addr_out,
  output logic                   rd_wen_out,
  output logic [`EXU_XLEN-1:0]   next_pc,
  output logic                   is_ecall,
  output logic                   is_mret,
  output logic                   is_mem,
  output logic [`EXU_XLEN-1:0]   mem_addr,
  output logic [`EXU_XLEN-1:0]   mem_wdata,
  output logic [`EXU_MASK_W-1:0] mem_wmask,
  output logic                   mem_wen,
  output logic [`EXU_SIZE_W-1:0] mem_size,
  output logic                   mem_unsigned
);

  import exu_pkg::*;

  logic                   held_valid;
  logic [`EXU_XLEN-1:0]   held_pc;
  logic [`EXU_XLEN-1:0]   held_rs1;
  logic [`EXU_XLEN-1:0]   held_rs2;
  logic [`EXU_XLEN-1:0]   held_imm;
  exu_op_e                held_op;
  logic [`EXU_REG_AW-1:0] held_rd_addr;
  logic                   held_rd_wen;
  logic [`EXU_XLEN-1:0]   held_mtvec;
  logic [`EXU_XLEN-1:0]   held_mepc;
  logic [`EXU_XLEN-1:0]   alu_result;
  logic [`EXU_XLEN-1:0]   target_pc; // datapath next pc, before commit
  logic                   commit_fire;

  exu_issue_reg issue_reg_i (
    .clk, .rst, .issue_valid, .issue_ready,
    .pc, .rs1_data, .rs2_data, .imm, .op, .rd_addr, .rd_wen, .mtvec, .mepc,
    .commit_fire, .held_valid, .held_pc, .held_rs1, .held_rs2, .held_imm,
    .held_op, .held_rd_addr, .held_rd_wen, .held_mtvec, .held_mepc
  );

  exu_alu_branch alu_branch_i (
    .held_pc, .held_rs1, .held_rs2, .held_imm, .held_op, .held_mtvec, .held_mepc,
    .alu_result, .next_pc(target_pc)
  );

  exu_commit commit_i (
    .held_valid, .held_op, .held_rs1, .held_rs2, .held_imm, .held_rd_addr,
    .held_rd_wen, .alu_result, .next_pc(target_pc), .commit_ready,
    .commit_valid, .commit_fire, .rd_data, .rd_addr(rd_addr_out),
    .rd_wen(rd_wen_out), .next_pc_out(next_pc), .is_ecall, .is_mret, .is_mem,
    .mem_addr, .mem_wdata, .mem_wmask, .mem_wen, .mem_size, .mem_unsigned
  );

endmodule

//--- list.f
+incdir+.
exu_pkg.sv
exu_issue_reg.sv
exu_alu_branch.sv
exu_commit.sv
exu_top.sv
tb_clkgen.sv
tb_exu.sv

//--- tb_clkgen.sv
// clock period must be an even number of ns; reset releases on a rising edge
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int period_ns    = 20,
  parameter int reset_cycles = 16
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // held over the first reset_cycles rising edges
  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

//--- tb_exu.sv
// reads exu_golden.txt from the working directory and keeps one instruction in flight
`timescale 1ns/1ps
`include "exu_settings.svh"

module tb_exu;

  import exu_pkg::*;

  localparam int wait_limit = 50; // cycles allowed per handshake wait

  logic                   clk;
  logic                   rst;
  logic                   issue_valid;
  logic                   issue_ready;
  logic [`EXU_XLEN-1:0]   pc;
  logic [`EXU_XLEN-1:0]   rs1_data;
  logic [`EXU_XLEN-1:0]   rs2_data;
  logic [`EXU_XLEN-1:0]   imm;
  exu_op_e                op;
  logic [`EXU_REG_AW-1:0] rd_addr;
  logic                   rd_wen;
  logic [`EXU_XLEN-1:0]   mtvec;
  logic [`EXU_XLEN-1:0]   mepc;
  logic                   commit_ready;
  logic                   commit_valid;
  logic [`EXU_XLEN-1:0]   rd_data;
  logic [`EXU_REG_AW-1:0] rd_addr_out;
  logic                   rd_wen_out;
  logic [`EXU_XLEN-1:0]   next_pc;
  logic                   is_ecall;
  logic                   is_mret;
  logic                   is_mem;
  logic [`EXU_XLEN-1:0]   mem_addr;
  logic [`EXU_XLEN-1:0]   mem_wdata;
  logic [`EXU_MASK_W-1:0] mem_wmask;
  logic                   mem_wen;
  logic [`EXU_SIZE_W-1:0] mem_size;
  logic                   mem_unsigned;

  // stimulus fields of the current golden line
  logic [`EXU_OP_W-1:0]   v_op;
  logic [`EXU_XLEN-1:0]   v_pc, v_rs1, v_rs2, v_imm, v_mtvec, v_mepc;
  logic [`EXU_REG_AW-1:0] v_rd_addr;
  logic                   v_rd_wen;
  // expected outputs of the same line
  logic [`EXU_XLEN-1:0]   e_rd_data, e_next_pc, e_mem_addr, e_mem_wdata;
  logic [`EXU_MASK_W-1:0] e_mem_wmask;
  logic [`EXU_SIZE_W-1:0] e_mem_size;
  logic                   e_is_mem, e_mem_wen, e_mem_uns, e_is_ecall, e_is_mret;

  int    fd;
  int    nread;
  int    vec_count;
  int    stall;
  string line;

  tb_clkgen #(.period_ns(20), .reset_cycles(16)) clkgen_i (.clk, .rst);

  exu_top dut_i (
    .clk, .rst, .issue_valid, .issue_ready, .pc, .rs1_data, .rs2_data, .imm, .op,
    .rd_addr, .rd_wen, .mtvec, .mepc, .commit_ready, .commit_valid, .rd_data,
    .rd_addr_out, .rd_wen_out, .next_pc, .is_ecall, .is_mret, .is_mem, .mem_addr,
    .mem_wdata, .mem_wmask, .mem_wen, .mem_size, .mem_unsigned
  );

  task automatic stop_with_error(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_word(input string name, input logic [`EXU_XLEN-1:0] got,
                              input logic [`EXU_XLEN-1:0] exp);
    if (got !== exp)
      stop_with_error($sformatf("Mismatch at %0t ns: %s got %h expected %h",
                                $time, name, got, exp));
  endtask

  task automatic compare_mask(input string name, input logic [`EXU_MASK_W-1:0] got,
                              input logic [`EXU_MASK_W-1:0] exp);
    if (got !== exp)
      stop_with_error($sformatf("Mismatch at %0t ns: %s got %b expected %b",
                                $time, name, got, exp));
  endtask

  task automatic compare_size(input string name, input logic [`EXU_SIZE_W-1:0] got,
                              input logic [`EXU_SIZE_W-1:0] exp);
    if (got !== exp)
      stop_with_error($sformatf("Mismatch at %0t ns: %s got %0d expected %0d",
                                $time, name, got, exp));
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_with_error($sformatf("Mismatch at %0t ns: %s got %b expected %b",
                                $time, name, got, exp));
  endtask

  task automatic compare_reg(input string name, input logic [`EXU_REG_AW-1:0] got,
                             input logic [`EXU_REG_AW-1:0] exp);
    if (got !== exp)
      stop_with_error($sformatf("Mismatch at %0t ns: %s got %0d expected %0d",
                                $time, name, got, exp));
  endtask

  // everything the output side shows while one instruction is held
  task automatic check_outputs;
    compare_flag("commit_valid", commit_valid, 1'b1);
    compare_flag("issue_ready", issue_ready, 1'b0); // slot busy
    compare_word("rd_data", rd_data, e_rd_data);
    compare_reg("rd_addr_out", rd_addr_out, v_rd_addr);
    compare_flag("rd_wen_out", rd_wen_out, v_rd_wen);
    compare_word("next_pc", next_pc, e_next_pc);
    compare_flag("is_mem", is_mem, e_is_mem);
    compare_word("mem_addr", mem_addr, e_mem_addr);
    compare_word("mem_wdata", mem_wdata, e_mem_wdata);
    compare_mask("mem_wmask", mem_wmask, e_mem_wmask);
    compare_flag("mem_wen", mem_wen, e_mem_wen);
    compare_size("mem_size", mem_size, e_mem_size);
    compare_flag("mem_unsigned", mem_unsigned, e_mem_uns);
    compare_flag("is_ecall", is_ecall, e_is_ecall);
    compare_flag("is_mret", is_mret, e_is_mret);
  endtask

  // nothing held, so every gated flag reads low
  task automatic check_empty(input string when);
    compare_flag({"issue_ready ", when}, issue_ready, 1'b1);
    compare_flag({"commit_valid ", when}, commit_valid, 1'b0);
    compare_flag({"is_mem ", when}, is_mem, 1'b0);
    compare_flag({"mem_wen ", when}, mem_wen, 1'b0);
    compare_flag({"mem_unsigned ", when}, mem_unsigned, 1'b0);
    compare_flag({"is_ecall ", when}, is_ecall, 1'b0);
    compare_flag({"is_mret ", when}, is_mret, 1'b0);
    compare_flag({"rd_wen_out ", when}, rd_wen_out, 1'b0);
  endtask

  // new values on every issue input while the held instruction waits
  task automatic scramble_issue_fields;
    pc       <= $urandom;
    rs1_data <= $urandom;
    rs2_data <= $urandom;
    imm      <= $urandom;
    op       <= exu_op_e'(`EXU_OP_W'($urandom));
    rd_addr  <= `EXU_REG_AW'($urandom);
    rd_wen   <= ~v_rd_wen;
    mtvec    <= $urandom;
    mepc     <= $urandom;
  endtask

  task automatic wait_reset_release;
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (rst !== 1'b0) begin
      if (cycles >= wait_limit)
        stop_with_error("reset was never released");
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic wait_issue_ready;
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (issue_ready !== 1'b1) begin
      if (cycles >= wait_limit)
        stop_with_error("issue handshake stalled, issue_ready stayed low for 50 cycles");
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic wait_commit_valid;
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (commit_valid !== 1'b1) begin
      if (cycles >= wait_limit)
        stop_with_error("output handshake stalled, commit_valid stayed low for 50 cycles");
      @(negedge clk);
      cycles++;
    end
  endtask

  // issue one golden line, stall the output a while, then let it commit
  task automatic run_vector;
    int i;
    stall = $urandom_range(3, 0);
    @(posedge clk);
    issue_valid <= 1'b1;
    pc          <= v_pc;
    rs1_data    <= v_rs1;
    rs2_data    <= v_rs2;
    imm         <= v_imm;
    op          <= exu_op_e'(v_op); // unknown codes pass through as is
    rd_addr     <= v_rd_addr;
    rd_wen      <= v_rd_wen;
    mtvec       <= v_mtvec;
    mepc        <= v_mepc;
    wait_issue_ready;
    @(posedge clk); // accepting edge
    issue_valid  <= 1'b0;
    commit_ready <= (stall == 0);
    scramble_issue_fields; // held copy must not follow the inputs
    wait_commit_valid;
    check_outputs;
    for (i = 0; i < stall; i++) begin
      @(posedge clk);
      commit_ready <= (i == stall - 1);
      @(negedge clk);
      check_outputs; // fields must hold under back-pressure
    end
    @(posedge clk); // output transfer
    commit_ready <= 1'b0;
    @(negedge clk);
    check_empty("after transfer");
  endtask

  initial begin
    issue_valid  = 1'b0;
    commit_ready = 1'b0;
    pc           = '0;
    rs1_data     = '0;
    rs2_data     = '0;
    imm          = '0;
    op           = op_addi;
    rd_addr      = '0;
    rd_wen       = 1'b0;
    mtvec        = '0;
    mepc         = '0;
    vec_count    = 0;
    void'($urandom(32'h5fa25337));

    wait_reset_release;
    check_empty("after reset");

    fd = $fopen("exu_golden.txt", "r");
    if (fd == 0)
      stop_with_error("could not open exu_golden.txt");
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line.getc(0) != "#") begin
        nread = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        v_op, v_pc, v_rs1, v_rs2, v_imm, v_mtvec, v_mepc, v_rd_addr,
                        v_rd_wen, e_rd_data, e_next_pc, e_is_mem, e_mem_addr, e_mem_wdata,
                        e_mem_wmask, e_mem_wen, e_mem_size, e_mem_uns, e_is_ecall,
                        e_is_mret);
        if (nread != 20)
          stop_with_error($sformatf("golden line %0d has %0d fields instead of 20",
                                    vec_count + 1, nread));
        run_vector;
        vec_count++;
      end
    end
    $fclose(fd);

    if (vec_count > 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      stop_with_error("exu_golden.txt held no instructions");
    end
  end

endmodule
